// File: hw/toneSynthPkg.sv
// ##############################
// toneSynthPkg
// register map and register word views
// for the tone synthesizer write port
// ##############################

`default_nettype none

package toneSynthPkg;

    localparam int REG_W = 16;          // width of one register write word

    // two live registers, addresses 2 and 3 are ignored
    typedef logic [1:0] regAddr_t;

    localparam regAddr_t NOTE_ADDR  = 2'd0;   // note, octave, waveform, enable
    localparam regAddr_t LEVEL_ADDR = 2'd1;   // volume only

    // note register layout, tone sits in the low nibble
    typedef struct packed {
        logic [5:0] reserved;           // ignored on write
        logic       enable;             // voice on
        logic [1:0] waveSel;            // raw waveform code
        logic [2:0] octave;             // phase step is 1 << octave
        logic [3:0] tone;               // 0..11 valid, do..si
    } noteWord_t;

    // level register layout
    typedef struct packed {
        logic [7:0] reserved;           // ignored on write
        logic [7:0] volume;             // linear scale, 255 is full
    } levelWord_t;

    // one write word, the address picks the view
    typedef union packed {
        noteWord_t  note;
        levelWord_t level;
    } regWord_u;

endpackage : toneSynthPkg

`default_nettype wire

// File: hw/toneTablePkg.sv
// ##############################
// toneTablePkg
// musical constants for a 25 MHz clock
// ##############################

`default_nettype none

package toneTablePkg;

    localparam int PHASE_W    = 8;      // 256 steps per waveform period, also sample width
    localparam int PRESCALE_W = 10;     // clocks between phase steps
    localparam int NOTE_COUNT = 12;     // one octave of semitones

    // clock count per phase step, 25e6 / 256 / f
    localparam logic [PRESCALE_W-1:0] PRESCALE_TABLE [NOTE_COUNT] = '{
        10'h175,    // do     261.62 Hz
        10'h160,    // do#    277.18 Hz
        10'h14C,    // re     293.66 Hz
        10'h139,    // re#    311.12 Hz
        10'h128,    // mi     329.62 Hz
        10'h117,    // fa     349.22 Hz
        10'h107,    // fa#    370.00 Hz
        10'h0F9,    // sol    392.00 Hz
        10'h0EB,    // sol#   415.30 Hz
        10'h0DD,    // la     440.00 Hz
        10'h0D1,    // la#    466.16 Hz
        10'h0C5     // si     493.88 Hz
    };

    // waveform codes as written in the note register
    typedef enum logic [1:0] {
        WAVE_SQUARE   = 2'd0,
        WAVE_SAW      = 2'd1,   // rising ramp
        WAVE_TRIANGLE = 2'd2,
        WAVE_FALL     = 2'd3    // falling ramp
    } waveSel_t;

endpackage : toneTablePkg

`default_nettype wire

// File: hw/noteCfgIf.sv
// ##############################
// noteCfgIf
// live note settings, register block to generator
// ##############################

`default_nettype none

interface noteCfgIf;
    import toneTablePkg::*;

    logic       enable;     // voice on
    waveSel_t   waveSel;    // waveform shape
    logic [2:0] octave;     // phase step exponent
    logic [3:0] tone;       // note index into the prescale table
    logic [7:0] volume;     // output scaling

    // register side owns every field
    modport regs (
        output enable,
        output waveSel,
        output octave,
        output tone,
        output volume
    );

    // tone generator side only looks
    modport gen (
        input enable,
        input waveSel,
        input octave,
        input tone,
        input volume
    );

endinterface : noteCfgIf

`default_nettype wire

// File: hw/toneRegs.sv
// ##############################
// toneRegs
// decodes write strobes into note and level
// settings, pulses restart on a note write
// ##############################

`default_nettype none

module toneRegs (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              regWe,      // one cycle per write
    input  toneSynthPkg::regAddr_t            regAddr,
    input  logic [toneSynthPkg::REG_W-1:0]    regWdata,
    noteCfgIf.regs                            cfg,
    output logic                              restart     // one cycle after a note write
);
    import toneSynthPkg::*;
    import toneTablePkg::*;

    regWord_u wrWord;       // same bits, note or level view
    logic     noteWr;
    logic     levelWr;

    assign wrWord  = regWdata;
    assign noteWr  = regWe && (regAddr == NOTE_ADDR);
    assign levelWr = regWe && (regAddr == LEVEL_ADDR);  // 2 and 3 fall through

    // note fields, all loaded together
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg.enable  <= 1'b0;            // silent out of reset
            cfg.waveSel <= WAVE_SQUARE;
            cfg.octave  <= '0;
            cfg.tone    <= '0;
        end else if (noteWr) begin
            cfg.enable  <= wrWord.note.enable;
            cfg.waveSel <= waveSel_t'(wrWord.note.waveSel);
            cfg.octave  <= wrWord.note.octave;
            cfg.tone    <= wrWord.note.tone;
        end
    end

    // volume lives on its own, writing it keeps the phase running
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg.volume <= '0;
        end else if (levelWr) begin
            cfg.volume <= wrWord.level.volume;
        end
    end

    // restart lines up with the first cycle the new note fields are visible
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            restart <= 1'b0;
        end else begin
            restart <= noteWr;  // level writes never restart
        end
    end

    // the address is decoded in the same cycle as the strobe
    regAddrKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        regWe |-> !$isunknown(regAddr)
    ) else $error("regAddr has unknown bits during a write");

endmodule : toneRegs

`default_nettype wire

// File: hw/toneDecoder.sv
// ##############################
// toneDecoder
// note number to 25 MHz prescale value
// ##############################

`default_nettype none

module toneDecoder (
    input  logic [3:0]                         tone,
    output logic [toneTablePkg::PRESCALE_W-1:0] preScaleValue,
    output logic                               toneValid    // low for notes 12..15
);
    import toneTablePkg::*;

    always_comb begin
        if (tone < NOTE_COUNT) begin
            preScaleValue = PRESCALE_TABLE[tone];   // do..si
            toneValid     = 1'b1;
        end else begin
            // no entry above si, the generator stays idle
            preScaleValue = '0;
            toneValid     = 1'b0;
        end
    end

endmodule : toneDecoder

`default_nettype wire

// File: hw/toneGenerator.sv
// ##############################
// toneGenerator
// prescale counter plus octave-stepped
// phase accumulator, one step per period
// ##############################

`default_nettype none

module toneGenerator (
    input  logic                            clk,
    input  logic                            rstN,
    noteCfgIf.gen                           cfg,
    input  logic                            restart,    // from a note write
    output logic                            step,       // one cycle per phase step
    output logic [toneTablePkg::PHASE_W-1:0] phaseOut    // valid with step
);
    import toneTablePkg::*;

    logic [PRESCALE_W-1:0] preScaleValue;   // clocks per step for this note
    logic                  toneValid;
    logic [PRESCALE_W-1:0] count;           // 0 .. preScaleValue-1
    logic [PRESCALE_W-1:0] lastCount;
    logic [PHASE_W-1:0]    phase;
    logic [PHASE_W-1:0]    phaseInc;        // 1 << octave
    logic                  running;
    logic                  wrapNow;

    toneDecoder toneDecoder_i (
        .tone          (cfg.tone),
        .preScaleValue (preScaleValue),
        .toneValid     (toneValid)
    );

    assign running   = cfg.enable && toneValid;
    assign lastCount = preScaleValue - PRESCALE_W'(1);
    assign phaseInc  = PHASE_W'(1) << cfg.octave;       // octave 7 gives half-period steps
    assign wrapNow   = running && !restart && (count == lastCount);

    // step carries the current phase and the advance follows the edge
    assign step     = wrapNow;
    assign phaseOut = phase;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            phase <= '0;
        end else if (restart || !running) begin
            // a new note or silence starts over from zero
            count <= '0;
            phase <= '0;
        end else if (wrapNow) begin
            count <= '0;
            phase <= phase + phaseInc;  // wraps mod 256
        end else begin
            count <= count + PRESCALE_W'(1);
        end
    end

    // a step needs a full count with enable already high the cycle before
    stepOnlyEnabled: assert property (
        @(posedge clk) disable iff (!rstN)
        step |-> $past(cfg.enable)
    ) else $error("step with enable low in the cycle before");

    // a note change may leave an old count for the restart cycle only
    countInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        (running && !restart) |-> (count < preScaleValue)
    ) else $error("prescale count 0x%0h not below 0x%0h", count, preScaleValue);

endmodule : toneGenerator

`default_nettype wire

// File: hw/waveShaper.sv
// ##############################
// waveShaper
// phase to waveform, volume scaling,
// registered sample with strobe
// ##############################

`default_nettype none

module waveShaper (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             step,
    input  logic [toneTablePkg::PHASE_W-1:0] phaseIn,
    input  toneTablePkg::waveSel_t           waveSel,
    input  logic [7:0]                       volume,
    output logic [toneTablePkg::PHASE_W-1:0] sample,        // unsigned, holds between strobes
    output logic                             sampleStrobe   // one cycle after step
);
    import toneTablePkg::*;

    logic [PHASE_W-1:0]   rawWave;  // full scale shape
    logic [2*PHASE_W-1:0] scaled;   // rawWave * volume

    // shapes computed straight from the phase
    always_comb begin
        case (waveSel)
            WAVE_SQUARE: begin
                rawWave = {PHASE_W{phaseIn[PHASE_W-1]}};     // 255 in upper half
            end
            WAVE_SAW: begin
                rawWave = phaseIn;
            end
            WAVE_TRIANGLE: begin
                // up at twice the rate, then mirrored back down
                if (phaseIn[PHASE_W-1]) begin
                    rawWave = {~phaseIn[PHASE_W-2:0], 1'b0};  // 2 * (255 - phase)
                end else begin
                    rawWave = {phaseIn[PHASE_W-2:0], 1'b0};   // 2 * phase
                end
            end
            WAVE_FALL: begin
                rawWave = ~phaseIn;     // 255 - phase
            end
            default: begin
                rawWave = '0;
            end
        endcase
    end

    assign scaled = rawWave * volume;   // volume 255 gives raw - 1 at most

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sample       <= '0;
            sampleStrobe <= 1'b0;
        end else begin
            sampleStrobe <= step;                           // back to back steps are fine
            if (step) begin
                sample <= scaled[2*PHASE_W-1:PHASE_W];      // keep the top byte
            end
        end
    end

endmodule : waveShaper

`default_nettype wire

// File: hw/toneSynth.sv
// ##############################
// toneSynth
// single voice tone synthesizer top level
// ##############################

`default_nettype none

module toneSynth (
    input  logic                              clk,          // 25 MHz board clock
    input  logic                              rstN,
    input  logic                              regWe,
    input  toneSynthPkg::regAddr_t            regAddr,
    input  logic [toneSynthPkg::REG_W-1:0]    regWdata,
    output logic [toneTablePkg::PHASE_W-1:0]  sample,
    output logic                              sampleStrobe
);
    import toneTablePkg::*;

    logic               restart;    // regs to generator
    logic               step;       // generator to shaper
    logic [PHASE_W-1:0] phase;

    noteCfgIf cfgIf ();

    toneRegs toneRegs_i (
        .clk      (clk),
        .rstN     (rstN),
        .regWe    (regWe),
        .regAddr  (regAddr),
        .regWdata (regWdata),
        .cfg      (cfgIf.regs),
        .restart  (restart)
    );

    toneGenerator toneGenerator_i (
        .clk      (clk),
        .rstN     (rstN),
        .cfg      (cfgIf.gen),
        .restart  (restart),
        .step     (step),
        .phaseOut (phase)
    );

    // shape and level come straight off the config bundle
    waveShaper waveShaper_i (
        .clk          (clk),
        .rstN         (rstN),
        .step         (step),
        .phaseIn      (phase),
        .waveSel      (cfgIf.waveSel),
        .volume       (cfgIf.volume),
        .sample       (sample),
        .sampleStrobe (sampleStrobe)
    );

endmodule : toneSynth

`default_nettype wire

// File: verification/toneSynthTb.sv
// ##############################
// toneSynthTb
// drives register writes into the tone synthesizer
// and checks every sample strobe against a model
// ##############################

`default_nettype none

module toneSynthTb;
    timeunit 1ns;
    timeprecision 100ps;

    import toneSynthPkg::*;
    import toneTablePkg::*;

    localparam logic [31:0] SEED = 32'ha2cdf2a2;
    localparam int NOTE_STROBES    = 4;     // per note in the scale sweep
    localparam int OCTAVE_STROBES  = 5;
    localparam int WAVE_STROBES    = 9;     // 3 before and 6 after the volume change
    localparam int RESTART_STROBES = 4;
    localparam int TOTAL_STROBES   = 12 * NOTE_STROBES + 8 * OCTAVE_STROBES
                                   + 4 * WAVE_STROBES + RESTART_STROBES;
    localparam int SILENT_CYCLES   = 50 + 5 * 1000;
    // slowest note spaces strobes 0x175 apart and the margin covers writes and first delay
    localparam int TIMEOUT_CYCLES  = TOTAL_STROBES * 'h175 + SILENT_CYCLES + 2000;

    logic               clk;
    logic               rstN;
    logic               regWe;
    regAddr_t           regAddr;
    logic [REG_W-1:0]   regWdata;
    logic [PHASE_W-1:0] sample;
    logic               sampleStrobe;

    // model state that the stimulus writes and the monitor reads
    logic               expectActive;
    logic [3:0]         curTone;
    logic [2:0]         curOctave;
    waveSel_t           curWave;
    logic [7:0]         curVolume;
    int                 strobeIdx;          // strobes since the last note write
    int                 lastStrobeCycle;
    int                 cycleCount;
    int                 passCount;
    int                 failCount;
    int                 testNum;
    int                 testFailStart;
    string              testName;
    int                 expPhase;
    logic [PRESCALE_W-1:0] expSpacing;
    logic [PHASE_W-1:0] heldSample;         // last expected sample that holds through silence
    logic [3:0]         randTone;

    toneSynth toneSynth_i (
        .clk          (clk),
        .rstN         (rstN),
        .regWe        (regWe),
        .regAddr      (regAddr),
        .regWdata     (regWdata),
        .sample       (sample),
        .sampleStrobe (sampleStrobe)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // expected sample from the waveform rules scaled and cut to the top byte
    function automatic logic [PHASE_W-1:0] refSample(input int phase, input waveSel_t wave,
                                                     input int volume);
        int raw;
        case (wave)
            WAVE_SQUARE:   raw = (phase >= 128) ? 255 : 0;
            WAVE_SAW:      raw = phase;
            WAVE_TRIANGLE: raw = (phase < 128) ? 2 * phase : 2 * (255 - phase);
            default:       raw = 255 - phase;   // falling saw
        endcase
        return PHASE_W'((raw * volume) / 256);
    endfunction

    function automatic int refPrescale(input int toneNum);
        return int'(PRESCALE_TABLE[toneNum]);
    endfunction

    task automatic checkSample(input logic [PHASE_W-1:0] actual,
                               input logic [PHASE_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error sample: got 0x%02h expected 0x%02h (strobe %0d)",
                     actual, expected, strobeIdx);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkSpacing(input logic [PRESCALE_W-1:0] actual,
                                input logic [PRESCALE_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error sampleStrobe spacing: got 0x%03h expected 0x%03h", actual, expected);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    // monitor samples at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rstN && sampleStrobe) begin
            if (!expectActive) begin
                $display("a sample strobe came at cycle %0d while the voice should be silent",
                         cycleCount);
                failCount++;
            end else begin
                expPhase   = (strobeIdx << curOctave) % 256;   // k steps of 1 << octave
                expSpacing = (strobeIdx == 0) ? PRESCALE_W'(refPrescale(int'(curTone)) + 2)
                                              : PRESCALE_W'(refPrescale(int'(curTone)));
                heldSample = refSample(expPhase, curWave, int'(curVolume));
                checkSample(sample, heldSample);
                checkSpacing(PRESCALE_W'(cycleCount - lastStrobeCycle), expSpacing);
                lastStrobeCycle = cycleCount;
                strobeIdx++;
            end
        end
    end

    // called right after a strobe so no step of the old note is in flight
    task automatic writeNote(input logic en, input waveSel_t wave, input logic [2:0] oct,
                             input logic [3:0] toneNum);
        noteWord_t word;
        word         = '0;
        word.enable  = en;
        word.waveSel = wave;
        word.octave  = oct;
        word.tone    = toneNum;
        @(posedge clk);
        regWe    <= 1'b1;
        regAddr  <= NOTE_ADDR;
        regWdata <= word;
        @(negedge clk);
        expectActive    = en && (toneNum < NOTE_COUNT);    // 12..15 stay silent
        curTone         = toneNum;
        curOctave       = oct;
        curWave         = wave;
        strobeIdx       = 0;
        lastStrobeCycle = cycleCount;   // first strobe comes P+2 after the drive edge
        @(posedge clk);
        regWe <= 1'b0;
    endtask

    task automatic writeLevel(input logic [7:0] vol);
        levelWord_t word;
        word        = '0;
        word.volume = vol;
        @(posedge clk);
        regWe    <= 1'b1;
        regAddr  <= LEVEL_ADDR;
        regWdata <= word;
        @(negedge clk);
        curVolume = vol;        // phase sequence keeps counting
        @(posedge clk);
        regWe <= 1'b0;
    endtask

    task automatic waitStrobes(input int total);
        wait (strobeIdx >= total);
    endtask

    task automatic beginTest(input string name);
        testNum++;
        testName      = name;
        testFailStart = failCount;
    endtask

    task automatic endTest();
        $display("test %0d %-24s %s", testNum, testName,
                 (failCount == testFailStart) ? "ok" : "failed");
    endtask

    // watchdog
    initial begin
        wait (cycleCount >= TIMEOUT_CYCLES);
        $display("timeout, the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        regWe        = 1'b0;
        regAddr      = NOTE_ADDR;
        regWdata     = '0;
        rstN         = 1'b0;
        expectActive = 1'b0;
        curTone      = '0;
        curOctave    = '0;
        curWave      = WAVE_SQUARE;
        curVolume    = '0;
        strobeIdx    = 0;
        cycleCount   = 0;
        passCount    = 0;
        failCount    = 0;
        testNum      = 0;
        heldSample   = '0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        beginTest("reset state");
        repeat (50) @(posedge clk);
        @(negedge clk);
        checkSample(sample, '0);
        endTest();

        beginTest("scale sweep");
        writeLevel(8'hFF);
        for (int t = 0; t < NOTE_COUNT; t++) begin
            writeNote(1'b1, WAVE_SAW, 3'd0, 4'(t));
            waitStrobes(NOTE_STROBES);
        end
        endTest();

        beginTest("octave steps");
        randTone = 4'($urandom % NOTE_COUNT);
        for (int o = 0; o < 8; o++) begin
            writeNote(1'b1, WAVE_SAW, 3'(o), randTone);
            waitStrobes(OCTAVE_STROBES);
        end
        endTest();

        beginTest("waveforms and volume");
        for (int w = 0; w < 4; w++) begin
            writeLevel(8'($urandom));
            writeNote(1'b1, waveSel_t'(w), 3'($urandom % 8), 4'($urandom % NOTE_COUNT));
            waitStrobes(3);
            writeLevel(8'($urandom));   // applies from the next strobe on
            waitStrobes(WAVE_STROBES);
        end
        endTest();

        beginTest("silence and restart");
        for (int t = NOTE_COUNT; t < 16; t++) begin
            writeNote(1'b1, WAVE_SAW, 3'd0, 4'(t));
            repeat (1000) @(posedge clk);
        end
        writeNote(1'b0, WAVE_SAW, 3'd0, 4'd9);     // valid note with the voice off
        repeat (1000) @(posedge clk);
        @(negedge clk);
        checkSample(sample, heldSample);            // strobes stop while the sample holds
        writeNote(1'b1, WAVE_TRIANGLE, 3'd2, 4'd4);
        waitStrobes(RESTART_STROBES);
        endTest();

        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : toneSynthTb

`default_nettype wire

// File: toneSynth.f
hw/toneSynthPkg.sv
hw/toneTablePkg.sv
hw/noteCfgIf.sv
hw/toneRegs.sv
hw/toneDecoder.sv
hw/toneGenerator.sv
hw/waveShaper.sv
hw/toneSynth.sv
verification/toneSynthTb.sv

// File: Makefile
# Verilator build and run for the tone synthesizer testbench

TOP       ?= toneSynthTb
FILELIST  ?= toneSynth.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
